//--- aesChecker.sv
/*
 * testbench monitor with a reference AES-128 model and its own CBC chaining value
 * checks each result and the req/ack timing, reports one line per block
 */
`default_nettype none

module aesChecker (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  input  logic             chainEnable,
  input  cipherPkg::blockT plainText,
  input  cipherPkg::blockT key,
  input  logic             ack,
  input  cipherPkg::blockT cipherText,
  input  int               testGroup,
  input  int               testIndex,
  output int               passCount,
  output int               failCount
);

  localparam cipherPkg::blockT KnownCipher = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  logic [7:0] sbox [256];
  logic [7:0] expT [256];
  int logT [256];
  logic [7:0] x;
  logic [7:0] inv;
  logic [7:0] aff;
  cipherPkg::blockT chainVal, expected, heldText, modelOut;
  logic busy, ackSeen, blockErr, holdBad, strayErr;
  int edgeCnt, relCnt;
  string testName;

  function automatic logic [7:0] dbl(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic string groupName(input int g);
    case (g)
      0: return "knownVector";
      1: return "randomEcb";
      2: return "cbcChain";
      default: return "mixedChain";
    endcase
  endfunction

  function automatic cipherPkg::blockT encryptBlock(input cipherPkg::blockT pt,
                                                    input cipherPkg::blockT k);
    logic [7:0] s [16];
    logic [7:0] t [16];
    logic [7:0] rk [16];
    logic [7:0] rc;
    logic [7:0] a0, a1, a2, a3;
    cipherPkg::blockT res;
    rc = 8'h01;
    for (int i = 0; i < 16; i++) begin
      rk[i] = k[127-8*i -: 8];
      s[i] = pt[127-8*i -: 8] ^ rk[i];
    end
    for (int rnd = 1; rnd <= 10; rnd++) begin
      // RotWord and SubWord of the last word, rcon on the first byte
      rk[0] = rk[0] ^ sbox[rk[13]] ^ rc;
      rk[1] = rk[1] ^ sbox[rk[14]];
      rk[2] = rk[2] ^ sbox[rk[15]];
      rk[3] = rk[3] ^ sbox[rk[12]];
      for (int i = 4; i < 16; i++) begin
        rk[i] = rk[i] ^ rk[i-4];
      end
      rc = dbl(rc);
      // row r of column c is taken from column c+r
      for (int i = 0; i < 16; i++) begin
        t[i] = sbox[s[(i % 4) + 4 * ((i / 4 + i % 4) % 4)]];
      end
      for (int c = 0; c < 4; c++) begin
        a0 = t[4*c];
        a1 = t[4*c+1];
        a2 = t[4*c+2];
        a3 = t[4*c+3];
        s[4*c] = (rnd < 10) ? dbl(a0) ^ dbl(a1) ^ a1 ^ a2 ^ a3 : a0;
        s[4*c+1] = (rnd < 10) ? a0 ^ dbl(a1) ^ dbl(a2) ^ a2 ^ a3 : a1;
        s[4*c+2] = (rnd < 10) ? a0 ^ a1 ^ dbl(a2) ^ dbl(a3) ^ a3 : a2;
        s[4*c+3] = (rnd < 10) ? dbl(a0) ^ a0 ^ a1 ^ a2 ^ dbl(a3) : a3;
      end
      for (int i = 0; i < 16; i++) begin
        s[i] = s[i] ^ rk[i];
      end
    end
    for (int i = 0; i < 16; i++) begin
      res[127-8*i -: 8] = s[i];
    end
    return res;
  endfunction

  // S-box from log tables over generator 3, then the affine map bit by bit
  initial begin
    passCount = 0;
    failCount = 0;
    busy = 1'b0;
    strayErr = 1'b0;
    x = 8'h01;
    for (int i = 0; i < 255; i++) begin
      expT[i] = x;
      logT[x] = i;
      x = x ^ dbl(x);
    end
    for (int a = 0; a < 256; a++) begin
      inv = (a == 0) ? 8'h00 : expT[(255 - logT[a]) % 255];
      for (int i = 0; i < 8; i++) begin
        aff[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
      end
      sbox[a] = aff ^ 8'h63;
    end
  end

  always @(negedge clk) begin
    if (rst) begin
      chainVal = '0;
      busy = 1'b0;
      if (ack !== 1'b0 && !strayErr) begin
        $display("ack is not low during reset");
        strayErr = 1'b1;
        failCount++;
      end
    end else begin
      if (busy) begin
        edgeCnt++;
        if (!ackSeen && ack === 1'b1) begin
          ackSeen = 1'b1;
          heldText = cipherText;
          chainVal = expected;
          if (edgeCnt != 11) begin
            $display("%s: ack rose %0d edges after req was sampled, not 11", testName, edgeCnt);
            blockErr = 1'b1;
          end
          if (cipherText !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, cipherText);
            blockErr = 1'b1;
          end
        end else if (!ackSeen && edgeCnt == 12) begin
          $display("%s: ack did not rise 11 edges after req was sampled", testName);
          blockErr = 1'b1;
        end
        if (ackSeen && relCnt == 0) begin
          if (req && !holdBad && (ack !== 1'b1 || cipherText !== heldText)) begin
            $display("%s: ack or cipherText changed while req was still high", testName);
            holdBad = 1'b1;
            blockErr = 1'b1;
          end else if (!req) begin
            relCnt = 1;
          end
        end else if (ackSeen) begin
          relCnt++;
          if (relCnt == 2 && ack !== 1'b1) begin
            $display("%s: ack fell on the same edge that sampled req low", testName);
            blockErr = 1'b1;
          end
          if (relCnt == 3) begin
            if (ack !== 1'b0) begin
              $display("%s: ack did not fall one cycle after req was sampled low", testName);
              blockErr = 1'b1;
            end
            if (blockErr) begin
              failCount++;
              $display("test %s failed", testName);
            end else begin
              passCount++;
              $display("test %s passed", testName);
            end
            busy = 1'b0;
          end
        end
      end
      if (!busy && ack === 1'b1 && !strayErr) begin
        $display("ack is high while no block is in flight");
        strayErr = 1'b1;
        failCount++;
      end else if (!busy && req === 1'b1) begin
        busy = 1'b1;
        ackSeen = 1'b0;
        blockErr = 1'b0;
        holdBad = 1'b0;
        edgeCnt = 0;
        relCnt = 0;
        testName = $sformatf("%s[%0d]", groupName(testGroup), testIndex);
        modelOut = encryptBlock(plainText ^ (chainEnable ? chainVal : '0), key);
        expected = modelOut;
        if (testGroup == 0) begin
          expected = KnownCipher;
          if (modelOut !== KnownCipher) begin
            $display("%s: reference model does not give the FIPS-197 ciphertext", testName);
            blockErr = 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- aesTop.sv
/*
 * iterative AES-128 encryption engine with req/ack handshake and CBC option
 */
`default_nettype none

module aesTop (
  input  logic               clk,
  input  logic               rst,
  input  logic               req,
  input  logic               chainEnable,
  input  cipherPkg::blockT   plainText,
  input  cipherPkg::blockT   key,
  output logic               ack,
  output cipherPkg::blockT   cipherText
);

  cipherPkg::blockT nextKey;

  roundCtrlIf ctrl ();

  handshakeFsm uFsm (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .ack  (ack),
    .ctrl (ctrl)
  );

  roundCounter uCounter (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl)
  );

  // current key register stays internal to the key schedule
  keySchedule uKeys (
    .clk      (clk),
    .key      (key),
    .ctrl     (ctrl),
    .roundKey (),
    .nextKey  (nextKey)
  );

  cipherRound uRound (
    .clk         (clk),
    .rst         (rst),
    .ctrl        (ctrl),
    .plainText   (plainText),
    .roundKey    (nextKey),
    .chainEnable (chainEnable),
    .result      (cipherText)
  );

endmodule

`default_nettype wire

//--- cipherPkg.sv
/*
 * AES-128 widths, block types and round count
 * GF(2^8) helpers for the round constant and the computed S-box
 */
`default_nettype none

package cipherPkg;

  localparam int BlockBits = 128;
  localparam int WordBits = 32;
  localparam int ByteBits = 8;
  localparam int NumRounds = 10;

  // constant added by the S-box affine map
  localparam logic [ByteBits-1:0] SboxAffine = 8'h63;

  typedef logic [BlockBits-1:0] blockT;
  typedef logic [WordBits-1:0] wordT;
  typedef logic [ByteBits-1:0] byteT;

  // multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic byteT xtime(input byteT b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  function automatic byteT gfMul(input byteT a, input byteT b);
    byteT acc;
    byteT cur;
    acc = '0;
    cur = a;
    for (int i = 0; i < ByteBits; i++) begin
      if (b[i]) begin
        acc = acc ^ cur;
      end
      cur = xtime(cur);
    end
    return acc;
  endfunction

  // rcon is 01 for round 1, doubled once per later round
  function automatic byteT rconFor(input logic [3:0] round);
    byteT rc;
    rc = 8'h01;
    for (int i = 2; i < 16; i++) begin
      if (i <= round) begin
        rc = xtime(rc);
      end
    end
    return rc;
  endfunction

endpackage

`default_nettype wire

//--- cipherRound.sv
/*
 * AES state register with one encryption round per clock
 * final round skips MixColumns, CBC chaining register holds the last ciphertext
 */
`default_nettype none

module cipherRound (
  input  logic                clk,
  input  logic                rst,
  roundCtrlIf.datapath        ctrl,
  input  cipherPkg::blockT    plainText,
  input  cipherPkg::blockT    roundKey,
  input  logic                chainEnable,
  output cipherPkg::blockT    result
);

  cipherPkg::blockT stateReg;
  cipherPkg::blockT chainReg;
  cipherPkg::blockT shifted;
  cipherPkg::blockT mixed;
  cipherPkg::blockT roundOut;
  cipherPkg::blockT nextState;
  cipherPkg::byteT  subOut [16];

  function automatic cipherPkg::wordT mixColumn(input cipherPkg::wordT col);
    cipherPkg::byteT a0, a1, a2, a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {cipherPkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
            cipherPkg::xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0,
            cipherPkg::xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1,
            cipherPkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
  endfunction

  // byte n of the block is row n%4, column n/4, starting at the msb
  for (genvar n = 0; n < 16; n++) begin : gSub
    sboxByte uSbox (
      .in  (stateReg[127-8*n -: 8]),
      .out (subOut[n])
    );
  end

  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted[127-8*(r+4*c) -: 8] = subOut[r + 4*((c + r) % 4)];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mixed[127-32*c -: 32] = mixColumn(shifted[127-32*c -: 32]);
    end
    roundOut = ctrl.finalRound ? shifted : mixed;
  end

  assign nextState = roundOut ^ roundKey;

  // roundKey carries the raw key during load
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      stateReg <= plainText ^ roundKey ^ (chainEnable ? chainReg : '0);
    end else if (ctrl.advance) begin
      stateReg <= nextState;
    end
  end

  // updated by every block so a later chained block sees the latest ciphertext
  always_ff @(posedge clk) begin
    if (rst) begin
      chainReg <= '0;
    end else if (ctrl.advance && ctrl.finalRound) begin
      chainReg <= nextState;
    end
  end

  assign result = stateReg;

endmodule

`default_nettype wire

//--- controlPkg.sv
/*
 * handshake FSM states and the round index type
 */
`default_nettype none

package controlPkg;

  localparam int RoundIdxBits = 4;

  typedef enum logic [1:0] {
    Idle,
    Run,
    Hold,
    Release
  } hsStateT;

  typedef logic [RoundIdxBits-1:0] roundIdxT;

endpackage

`default_nettype wire

//--- flist.f
cipherPkg.sv
controlPkg.sv
roundCtrlIf.sv
sboxByte.sv
cipherRound.sv
keySchedule.sv
roundCounter.sv
handshakeFsm.sv
aesTop.sv
aesChecker.sv
tbAes.sv

//--- handshakeFsm.sv
/*
 * four-phase req/ack FSM, steers block load, rounds and result hold
 */
`default_nettype none

module handshakeFsm (
  input  logic        clk,
  input  logic        rst,
  input  logic        req,
  output logic        ack,
  roundCtrlIf.fsm     ctrl
);

  controlPkg::hsStateT state;
  controlPkg::hsStateT stateNext;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= controlPkg::Idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      controlPkg::Idle: begin
        if (req) begin
          stateNext = controlPkg::Run;
        end
      end
      controlPkg::Run: begin
        if (ctrl.advance && ctrl.finalRound) begin
          stateNext = controlPkg::Hold;
        end
      end
      // output stays put until the producer drops req
      controlPkg::Hold: begin
        if (!req) begin
          stateNext = controlPkg::Release;
        end
      end
      controlPkg::Release: begin
        stateNext = controlPkg::Idle;
      end
      default: begin
        stateNext = controlPkg::Idle;
      end
    endcase
  end

  assign ctrl.load = (state == controlPkg::Idle) && req;
  assign ctrl.advance = (state == controlPkg::Run);
  assign ack = (state == controlPkg::Hold) || (state == controlPkg::Release);

endmodule

`default_nettype wire

//--- keySchedule.sv
/*
 * on-the-fly AES-128 key expansion, one round key per clock
 */
`default_nettype none

module keySchedule (
  input  logic                clk,
  input  cipherPkg::blockT    key,
  roundCtrlIf.datapath        ctrl,
  output cipherPkg::blockT    roundKey,
  output cipherPkg::blockT    nextKey
);

  cipherPkg::wordT  w0, w1, w2, w3;
  cipherPkg::wordT  rotWord;
  cipherPkg::wordT  subWord;
  cipherPkg::wordT  temp;
  cipherPkg::blockT expanded;
  cipherPkg::byteT  subOut [4];

  assign {w0, w1, w2, w3} = roundKey;
  assign rotWord = {w3[23:0], w3[31:24]};

  for (genvar i = 0; i < 4; i++) begin : gSubWord
    sboxByte uSbox (
      .in  (rotWord[31-8*i -: 8]),
      .out (subOut[i])
    );
  end

  assign subWord = {subOut[0], subOut[1], subOut[2], subOut[3]};

  // roundIdx is the round whose key is being produced
  assign temp = subWord ^ {cipherPkg::rconFor(ctrl.roundIdx), 24'h000000};

  always_comb begin
    expanded[127:96] = w0 ^ temp;
    expanded[95:64] = w1 ^ expanded[127:96];
    expanded[63:32] = w2 ^ expanded[95:64];
    expanded[31:0] = w3 ^ expanded[63:32];
  end

  // the raw key is the whitening key of the load cycle
  assign nextKey = ctrl.load ? key : expanded;

  always_ff @(posedge clk) begin
    if (ctrl.load || ctrl.advance) begin
      roundKey <= nextKey;
    end
  end

endmodule

`default_nettype wire

//--- roundCounter.sv
/*
 * round index counter with final round flag
 */
`default_nettype none

module roundCounter (
  input logic           clk,
  input logic           rst,
  roundCtrlIf.counter   ctrl
);

  // round 1 runs in the cycle right after load
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.roundIdx <= '0;
    end else if (ctrl.load) begin
      ctrl.roundIdx <= controlPkg::roundIdxT'(1);
    end else if (ctrl.advance) begin
      ctrl.roundIdx <= ctrl.roundIdx + 1'b1;
    end
  end

  assign ctrl.finalRound = (ctrl.roundIdx == controlPkg::roundIdxT'(cipherPkg::NumRounds));

endmodule

`default_nettype wire

//--- roundCtrlIf.sv
/*
 * round control between the handshake FSM, the round counter and the datapath
 */
`default_nettype none

interface roundCtrlIf;

  // one-cycle pulse when a new block is accepted
  logic load;
  // high for every round edge
  logic advance;
  controlPkg::roundIdxT roundIdx;
  logic finalRound;

  modport fsm (
    output load,
    output advance,
    input  finalRound
  );

  modport counter (
    input  load,
    input  advance,
    output roundIdx,
    output finalRound
  );

  modport datapath (
    input load,
    input advance,
    input roundIdx,
    input finalRound
  );

endinterface

`default_nettype wire

//--- sboxByte.sv
/*
 * AES S-box for one byte, computed as GF(2^8) inverse plus affine map
 */
`default_nettype none

module sboxByte (
  input  cipherPkg::byteT in,
  output cipherPkg::byteT out
);

  cipherPkg::byteT x2;
  cipherPkg::byteT x3;
  cipherPkg::byteT x6;
  cipherPkg::byteT x12;
  cipherPkg::byteT x15;
  cipherPkg::byteT x30;
  cipherPkg::byteT x60;
  cipherPkg::byteT x120;
  cipherPkg::byteT x240;
  cipherPkg::byteT x252;
  cipherPkg::byteT inv;

  // inverse is in^254, which also maps zero to zero
  assign x2 = cipherPkg::gfMul(in, in);
  assign x3 = cipherPkg::gfMul(x2, in);
  assign x6 = cipherPkg::gfMul(x3, x3);
  assign x12 = cipherPkg::gfMul(x6, x6);
  assign x15 = cipherPkg::gfMul(x12, x3);
  assign x30 = cipherPkg::gfMul(x15, x15);
  assign x60 = cipherPkg::gfMul(x30, x30);
  assign x120 = cipherPkg::gfMul(x60, x60);
  assign x240 = cipherPkg::gfMul(x120, x120);
  assign x252 = cipherPkg::gfMul(x240, x12);
  assign inv = cipherPkg::gfMul(x252, x2);

  // affine map as xor of left rotations by 0 to 4
  assign out = inv
             ^ {inv[6:0], inv[7]}
             ^ {inv[5:0], inv[7:6]}
             ^ {inv[4:0], inv[7:5]}
             ^ {inv[3:0], inv[7:4]}
             ^ cipherPkg::SboxAffine;

endmodule

`default_nettype wire

//--- tbAes.sv
/*
 * testbench top: clock, reset, seeded random blocks over req/ack, timeout
 */
`default_nettype none

module tbAes;

  localparam int Seed = 24765;
  localparam int ResetCycles = 16;
  localparam int NumRandom = 40;
  localparam int NumCbc = 20;
  localparam int NumMixed = 12;
  localparam int NumBlocks = 1 + NumRandom + NumCbc + NumMixed;
  // a block needs at most 11 edges to ack, 5 hold cycles and 2 to release
  localparam int TimeoutCycles = NumBlocks * 20 + ResetCycles;

  logic clk;
  logic rst;
  logic req;
  logic chainEnable;
  cipherPkg::blockT plainText;
  cipherPkg::blockT key;
  logic ack;
  cipherPkg::blockT cipherText;
  cipherPkg::blockT cbcKey;
  int testGroup;
  int testIndex;
  int passCount;
  int failCount;
  int seedVal;
  int cycleCount = 0;

  aesTop DUT (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .chainEnable (chainEnable),
    .plainText   (plainText),
    .key         (key),
    .ack         (ack),
    .cipherText  (cipherText)
  );

  aesChecker uChecker (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .chainEnable (chainEnable),
    .plainText   (plainText),
    .key         (key),
    .ack         (ack),
    .cipherText  (cipherText),
    .testGroup   (testGroup),
    .testIndex   (testIndex),
    .passCount   (passCount),
    .failCount   (failCount)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic cipherPkg::blockT randomBlock();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // called 1 time unit after a rising edge, returns the same way
  task automatic sendBlock(input int group, input int idx, input cipherPkg::blockT pt,
                           input cipherPkg::blockT k, input logic chain);
    int holdCycles;
    testGroup = group;
    testIndex = idx;
    plainText = pt;
    key = k;
    chainEnable = chain;
    req = 1'b1;
    while (ack !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    holdCycles = $urandom_range(5, 0);
    repeat (holdCycles) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    while (ack !== 1'b0) begin
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    seedVal = $urandom(Seed);
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    chainEnable = 1'b0;
    plainText = '0;
    key = '0;
    testGroup = 0;
    testIndex = 0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    sendBlock(0, 0, 128'h00112233445566778899aabbccddeeff,
              128'h000102030405060708090a0b0c0d0e0f, 1'b0);
    for (int i = 0; i < NumRandom; i++) begin
      sendBlock(1, i, randomBlock(), randomBlock(), 1'b0);
    end
    cbcKey = randomBlock();
    // short reset so the chained run starts from a zero chaining value
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < NumCbc; i++) begin
      sendBlock(2, i, randomBlock(), cbcKey, 1'b1);
    end
    // unchained blocks in between still move the chaining value
    for (int i = 0; i < NumMixed; i++) begin
      sendBlock(3, i, randomBlock(), randomBlock(), (i % 2) == 1);
    end
    repeat (2) @(posedge clk);
    $display("tests done: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0 && passCount == NumBlocks) begin
      $display("RESULT: PASS");
    end else begin
      if (passCount + failCount < NumBlocks) begin
        $display("only %0d of %0d blocks were checked", passCount + failCount, NumBlocks);
      end
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
